// ==== sim.f ====
source/mips_lite_pkg.sv
source/core_bus_if.sv
source/decode_if.sv
source/axi_lite_bus.sv
source/core_sequencer.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/mips_lite_top.sv
testbench/axi_lite_mem_model.sv
testbench/tb_mips_lite.sv

// ==== Bender.yml ====
package:
  name: mips_lite

sources:
  - source/mips_lite_pkg.sv
  - source/core_bus_if.sv
  - source/decode_if.sv
  - source/axi_lite_bus.sv
  - source/core_sequencer.sv
  - source/decode_unit.sv
  - source/execute_unit.sv
  - source/result_unit.sv
  - source/mips_lite_top.sv
  - target: test
    files:
      - testbench/axi_lite_mem_model.sv
      - testbench/tb_mips_lite.sv

// ==== testbench/tb_mips_lite.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_lite;

    typedef struct packed {
        mips_lite_pkg::word_t    pc;
        mips_lite_pkg::reg_idx_t wnum;
        mips_lite_pkg::word_t    wdata;
    } trace_t;

    logic                    aclk = 1'b0;
    logic                    arst_n;
    mips_lite_pkg::word_t    awaddr;
    logic [2:0]              awprot;
    logic                    awvalid;
    logic                    awready;
    mips_lite_pkg::word_t    wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    mips_lite_pkg::word_t    araddr;
    logic [2:0]              arprot;
    logic                    arvalid;
    logic                    arready;
    mips_lite_pkg::word_t    rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    mips_lite_pkg::word_t    debug_wb_pc;
    logic [3:0]              debug_wb_rf_wen;
    mips_lite_pkg::reg_idx_t debug_wb_rf_wnum;
    mips_lite_pkg::word_t    debug_wb_rf_wdata;

    mips_lite_pkg::word_t    prog [$];      // program words from address 0
    trace_t                  expected [$];  // one record per register write
    int                      cycles = 0;
    int                      max_cycles;

    mips_lite_top #(.reset_pc(32'h0000_0000)) uut (.*);

    axi_lite_mem_model mem_model (.*);

    always #10 aclk = ~aclk;

    function automatic mips_lite_pkg::word_t r_type(input logic [5:0] funct,
            input mips_lite_pkg::reg_idx_t rd, input mips_lite_pkg::reg_idx_t rs,
            input mips_lite_pkg::reg_idx_t rt);
        return {mips_lite_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_lite_pkg::word_t i_type(input logic [5:0] op,
            input mips_lite_pkg::reg_idx_t rt, input mips_lite_pkg::reg_idx_t rs,
            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic expect_write(input mips_lite_pkg::word_t pc,
            input mips_lite_pkg::reg_idx_t wnum, input mips_lite_pkg::word_t wdata);
        expected.push_back(trace_t'{pc, wnum, wdata});
    endtask

    // each instruction followed by the write it should retire
    task automatic build_tables;
        prog.push_back(i_type(mips_lite_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
        expect_write(32'h00, 5'd1, 32'h0000_0005);
        prog.push_back(i_type(mips_lite_pkg::OP_ADDIU, 5'd2, 5'd0, 16'hfffd));  // -3
        expect_write(32'h04, 5'd2, 32'hffff_fffd);
        prog.push_back(i_type(mips_lite_pkg::OP_ORI, 5'd3, 5'd0, 16'h80f3));    // zero extended
        expect_write(32'h08, 5'd3, 32'h0000_80f3);
        prog.push_back(i_type(mips_lite_pkg::OP_LUI, 5'd4, 5'd0, 16'h1234));
        expect_write(32'h0c, 5'd4, 32'h1234_0000);
        prog.push_back(r_type(mips_lite_pkg::FN_ADDU, 5'd5, 5'd1, 5'd2));
        expect_write(32'h10, 5'd5, 32'h0000_0002);
        prog.push_back(r_type(mips_lite_pkg::FN_SUBU, 5'd6, 5'd1, 5'd2));
        expect_write(32'h14, 5'd6, 32'h0000_0008);
        prog.push_back(r_type(mips_lite_pkg::FN_AND, 5'd7, 5'd3, 5'd2));
        expect_write(32'h18, 5'd7, 32'h0000_80f1);
        prog.push_back(r_type(mips_lite_pkg::FN_OR, 5'd8, 5'd3, 5'd4));
        expect_write(32'h1c, 5'd8, 32'h1234_80f3);
        prog.push_back(r_type(mips_lite_pkg::FN_XOR, 5'd9, 5'd3, 5'd2));
        expect_write(32'h20, 5'd9, 32'hffff_7f0e);
        prog.push_back(r_type(mips_lite_pkg::FN_SLT, 5'd10, 5'd2, 5'd1));  // -3 < 5
        expect_write(32'h24, 5'd10, 32'h0000_0001);
        prog.push_back(r_type(mips_lite_pkg::FN_SLT, 5'd11, 5'd1, 5'd2));
        expect_write(32'h28, 5'd11, 32'h0000_0000);
        prog.push_back(i_type(mips_lite_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd7));  // no trace
        prog.push_back(r_type(mips_lite_pkg::FN_ADDU, 5'd12, 5'd0, 5'd1));  // r0 still zero
        expect_write(32'h30, 5'd12, 32'h0000_0005);
        prog.push_back(i_type(mips_lite_pkg::OP_SW, 5'd8, 5'd1, 16'h007b));  // to 0x80
        prog.push_back(i_type(mips_lite_pkg::OP_LW, 5'd13, 5'd0, 16'h0080));
        expect_write(32'h38, 5'd13, 32'h1234_80f3);
        prog.push_back(i_type(mips_lite_pkg::OP_BEQ, 5'd8, 5'd13, 16'd1));  // taken to 0x44
        prog.push_back(i_type(mips_lite_pkg::OP_ADDIU, 5'd14, 5'd0, 16'h0099));
        prog.push_back(i_type(mips_lite_pkg::OP_BNE, 5'd12, 5'd1, 16'd1));  // falls through
        prog.push_back(i_type(mips_lite_pkg::OP_ADDIU, 5'd15, 5'd0, 16'h0077));
        expect_write(32'h48, 5'd15, 32'h0000_0077);
        prog.push_back(i_type(mips_lite_pkg::OP_ADDIU, 5'd16, 5'd13, 16'd1));
        expect_write(32'h4c, 5'd16, 32'h1234_80f4);
    endtask

    task automatic load_memory;
        mips_lite_pkg::word_t fill;
        for (int i = 0; i < 64; i++) begin
            fill = {6'b000000, 20'(i * 4), 6'b000000};  // nop carrying its own address
            if (i < prog.size()) fill = prog[i];
            mem_model.mem[i] = fill;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected_val);
        if (actual !== expected_val) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected_val);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // one-cycle trace pulse spans exactly one falling edge
    task automatic wait_for_write;
        do begin
            @(negedge aclk);
        end while (debug_wb_rf_wen == 4'h0);
    endtask

    // protection and strobe are fixed whenever an address or data beat is offered
    always @(negedge aclk) begin
        if (arvalid) check_value("arprot", 32'(arprot), 32'h0);
        if (awvalid) check_value("awprot", 32'(awprot), 32'h0);
        if (wvalid) check_value("wstrb", 32'(wstrb), 32'hf);
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("ERRORS FOUND");
            $display("timeout, run passed %0d cycles before all writes were seen", max_cycles);
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        arst_n = 1'b0;
        build_tables();
        max_cycles = 200 * expected.size();
        load_memory();
        repeat (5) @(negedge aclk);
        arst_n = 1'b1;
        foreach (expected[k]) begin
            wait_for_write();
            check_value("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'hf);
            check_value("debug_wb_pc", debug_wb_pc, expected[k].pc);
            check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(expected[k].wnum));
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, expected[k].wdata);
        end
        check_value("mem word at 0x80", mem_model.mem[32], 32'h1234_80f3);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/axi_lite_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

// word memory behind an AXI4-Lite slave, ready and response stalls of 0 to 3 cycles
module axi_lite_mem_model (
    input  logic                 aclk,
    input  logic                 arst_n,
    input  mips_lite_pkg::word_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  mips_lite_pkg::word_t wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  mips_lite_pkg::word_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output mips_lite_pkg::word_t rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    mips_lite_pkg::word_t mem [64];   // indexed by byte address bits 7:2
    integer               seed = 32'h69b3;

    logic                 ar_hs;      // handshakes seen at the last rising edge
    logic                 r_hs;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 b_hs;
    mips_lite_pkg::word_t rd_addr;
    mips_lite_pkg::word_t wr_addr;
    mips_lite_pkg::word_t wr_data;
    logic                 r_pend;
    logic                 b_pend;
    logic                 aw_got;
    logic                 w_got;
    logic [1:0]           ar_wait;
    logic [1:0]           r_wait;
    logic [1:0]           aw_wait;
    logic [1:0]           w_wait;
    logic [1:0]           b_wait;

    assign rresp = 2'b00;
    assign bresp = 2'b00;

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ar_hs <= 1'b0;
            r_hs  <= 1'b0;
            aw_hs <= 1'b0;
            w_hs  <= 1'b0;
            b_hs  <= 1'b0;
        end else begin
            ar_hs <= arvalid && arready;
            r_hs  <= rvalid && rready;
            aw_hs <= awvalid && awready;
            w_hs  <= wvalid && wready;
            b_hs  <= bvalid && bready;
            if (arvalid && arready) rd_addr <= araddr;
            if (awvalid && awready) wr_addr <= awaddr;
            if (wvalid && wready) wr_data <= wdata;
        end
    end

    // all outputs change on the falling edge
    always @(negedge aclk) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            r_pend  <= 1'b0;
            b_pend  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_wait <= 2'd0;
            r_wait  <= 2'd0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            b_wait  <= 2'd0;
        end else begin
            if (ar_hs) begin
                arready <= 1'b0;
                r_pend  <= 1'b1;
            end else if (arvalid && !arready) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                    ar_wait <= 2'($random(seed));
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end

            if (r_hs) begin
                rvalid <= 1'b0;
            end else if (r_pend && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_addr[7:2]];
                    r_pend <= 1'b0;
                    r_wait <= 2'($random(seed));
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end

            if (aw_hs) begin
                awready <= 1'b0;
            end else if (awvalid && !awready) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                    aw_wait <= 2'($random(seed));
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end

            if (w_hs) begin
                wready <= 1'b0;
            end else if (wvalid && !wready) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                    w_wait <= 2'($random(seed));
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end

            // aw and w may arrive in either order
            if ((aw_got || aw_hs) && (w_got || w_hs)) begin
                mem[wr_addr[7:2]] <= wr_data;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
            end else begin
                if (aw_hs) aw_got <= 1'b1;
                if (w_hs) w_got <= 1'b1;
            end

            if (b_hs) begin
                bvalid <= 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_wait == 2'd0) begin
                    bvalid <= 1'b1;
                    b_pend <= 1'b0;
                    b_wait <= 2'($random(seed));
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mips_lite_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_lite_top #(
    parameter mips_lite_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                    aclk,
    input  logic                    arst_n,
    // AXI4-Lite master
    output mips_lite_pkg::word_t    awaddr,
    output logic [2:0]              awprot,
    output logic                    awvalid,
    input  logic                    awready,
    output mips_lite_pkg::word_t    wdata,
    output logic [3:0]              wstrb,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic [1:0]              bresp,
    input  logic                    bvalid,
    output logic                    bready,
    output mips_lite_pkg::word_t    araddr,
    output logic [2:0]              arprot,
    output logic                    arvalid,
    input  logic                    arready,
    input  mips_lite_pkg::word_t    rdata,
    input  logic [1:0]              rresp,
    input  logic                    rvalid,
    output logic                    rready,
    // trace
    output mips_lite_pkg::word_t    debug_wb_pc,
    output logic [3:0]              debug_wb_rf_wen,
    output mips_lite_pkg::reg_idx_t debug_wb_rf_wnum,
    output mips_lite_pkg::word_t    debug_wb_rf_wdata
);

    core_bus_if bus_if ();
    decode_if   dec_if ();

    mips_lite_pkg::word_t pc;
    mips_lite_pkg::word_t rs_val;
    mips_lite_pkg::word_t rt_val;
    mips_lite_pkg::word_t alu_result;
    mips_lite_pkg::word_t mem_addr;
    mips_lite_pkg::word_t store_data;
    mips_lite_pkg::word_t branch_target;
    mips_lite_pkg::word_t load_data;
    logic                 take_branch;
    logic                 load_ir;
    logic                 retire;

    axi_lite_bus axi_lite_bus (
        .aclk    (aclk   ),
        .arst_n  (arst_n ),
        .bus     (bus_if ),
        .awaddr  (awaddr ),
        .awprot  (awprot ),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata  ),
        .wstrb   (wstrb  ),
        .wvalid  (wvalid ),
        .wready  (wready ),
        .bresp   (bresp  ),
        .bvalid  (bvalid ),
        .bready  (bready ),
        .araddr  (araddr ),
        .arprot  (arprot ),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata  ),
        .rresp   (rresp  ),
        .rvalid  (rvalid ),
        .rready  (rready )
    );

    core_sequencer #(.reset_pc(reset_pc)) core_sequencer (
        .aclk          (aclk         ),
        .arst_n        (arst_n       ),
        .bus           (bus_if       ),
        .dec           (dec_if       ),
        .mem_addr      (mem_addr     ),
        .store_data    (store_data   ),
        .take_branch   (take_branch  ),
        .branch_target (branch_target),
        .pc            (pc           ),
        .load_ir       (load_ir      ),
        .retire        (retire       ),
        .load_data     (load_data    )
    );

    // fetched word comes straight from the bus unit
    decode_unit decode_unit (
        .aclk    (aclk        ),
        .arst_n  (arst_n      ),
        .load_ir (load_ir     ),
        .instr   (bus_if.rdata),
        .dec     (dec_if      )
    );

    execute_unit execute_unit (
        .dec           (dec_if       ),
        .rs_val        (rs_val       ),
        .rt_val        (rt_val       ),
        .pc            (pc           ),
        .alu_result    (alu_result   ),
        .mem_addr      (mem_addr     ),
        .store_data    (store_data   ),
        .branch_target (branch_target),
        .take_branch   (take_branch  )
    );

    result_unit result_unit (
        .aclk              (aclk             ),
        .arst_n            (arst_n           ),
        .dec               (dec_if           ),
        .retire            (retire           ),
        .alu_result        (alu_result       ),
        .load_data         (load_data        ),
        .pc                (pc               ),
        .rs_val            (rs_val           ),
        .rt_val            (rt_val           ),
        .debug_wb_pc       (debug_wb_pc      ),
        .debug_wb_rf_wen   (debug_wb_rf_wen  ),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum ),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// ==== source/result_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_unit (
    input  logic                    aclk,
    input  logic                    arst_n,
    decode_if.sink                  dec,
    input  logic                    retire,
    input  mips_lite_pkg::word_t    alu_result,
    input  mips_lite_pkg::word_t    load_data,
    input  mips_lite_pkg::word_t    pc,
    output mips_lite_pkg::word_t    rs_val,
    output mips_lite_pkg::word_t    rt_val,
    output mips_lite_pkg::word_t    debug_wb_pc,
    output logic [3:0]              debug_wb_rf_wen,
    output mips_lite_pkg::reg_idx_t debug_wb_rf_wnum,
    output mips_lite_pkg::word_t    debug_wb_rf_wdata
);

    mips_lite_pkg::word_t regs [32];
    mips_lite_pkg::word_t wb_data;
    logic                 wb_en;

    assign wb_data = dec.is_load ? load_data : alu_result;
    assign wb_en   = retire && dec.writes_reg && (dec.dest != 5'd0);  // r0 never written

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wb_en) begin
            regs[dec.dest] <= wb_data;
        end
    end

    assign rs_val = (dec.rs == 5'd0) ? '0 : regs[dec.rs];
    assign rt_val = (dec.rt == 5'd0) ? '0 : regs[dec.rt];

    // trace shows the write as it happens
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_wen   = {4{wb_en}};
    assign debug_wb_rf_wnum  = dec.dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    decode_if.sink               dec,
    input  mips_lite_pkg::word_t rs_val,
    input  mips_lite_pkg::word_t rt_val,
    input  mips_lite_pkg::word_t pc,
    output mips_lite_pkg::word_t alu_result,
    output mips_lite_pkg::word_t mem_addr,
    output mips_lite_pkg::word_t store_data,
    output mips_lite_pkg::word_t branch_target,
    output logic                 take_branch
);

    mips_lite_pkg::word_t op_b;

    assign op_b = dec.use_imm ? dec.imm : rt_val;

    always_comb begin
        case (dec.alu_op)
            mips_lite_pkg::ALU_SUB: alu_result = rs_val - op_b;
            mips_lite_pkg::ALU_AND: alu_result = rs_val & op_b;
            mips_lite_pkg::ALU_OR:  alu_result = rs_val | op_b;
            mips_lite_pkg::ALU_XOR: alu_result = rs_val ^ op_b;
            mips_lite_pkg::ALU_SLT: alu_result = {31'd0, $signed(rs_val) < $signed(op_b)};
            mips_lite_pkg::ALU_LUI: alu_result = {dec.imm[15:0], 16'h0000};
            default:                alu_result = rs_val + op_b;
        endcase
    end

    // lw and sw decode to ALU_ADD with the immediate
    assign mem_addr   = alu_result;
    assign store_data = rt_val;

    assign take_branch = (dec.is_beq && (rs_val == rt_val)) ||
                         (dec.is_bne && (rs_val != rt_val));
    assign branch_target = pc + 32'd4 + {dec.imm[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input  logic                 aclk,
    input  logic                 arst_n,
    input  logic                 load_ir,
    input  mips_lite_pkg::word_t instr,
    decode_if.source             dec
);

    mips_lite_pkg::word_t ir;
    logic [5:0]           opcode;
    logic [5:0]           funct;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;   // sll r0 = nop
        end else if (load_ir) begin
            ir <= instr;
        end
    end

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];

    assign dec.rs   = ir[25:21];
    assign dec.rt   = ir[20:16];
    assign dec.dest = (opcode == mips_lite_pkg::OP_SPECIAL) ? ir[15:11] : ir[20:16];
    assign dec.imm  = (opcode == mips_lite_pkg::OP_ORI) ? {16'h0000, ir[15:0]} :
                                                          {{16{ir[15]}}, ir[15:0]};

    always_comb begin
        dec.alu_op     = mips_lite_pkg::ALU_ADD;
        dec.use_imm    = 1'b0;
        dec.writes_reg = 1'b0;
        dec.is_load    = 1'b0;
        dec.is_store   = 1'b0;
        dec.is_beq     = 1'b0;
        dec.is_bne     = 1'b0;
        case (opcode)
            mips_lite_pkg::OP_SPECIAL: begin
                dec.writes_reg = 1'b1;
                case (funct)
                    mips_lite_pkg::FN_ADDU: dec.alu_op = mips_lite_pkg::ALU_ADD;
                    mips_lite_pkg::FN_SUBU: dec.alu_op = mips_lite_pkg::ALU_SUB;
                    mips_lite_pkg::FN_AND:  dec.alu_op = mips_lite_pkg::ALU_AND;
                    mips_lite_pkg::FN_OR:   dec.alu_op = mips_lite_pkg::ALU_OR;
                    mips_lite_pkg::FN_XOR:  dec.alu_op = mips_lite_pkg::ALU_XOR;
                    mips_lite_pkg::FN_SLT:  dec.alu_op = mips_lite_pkg::ALU_SLT;
                    default:                dec.writes_reg = 1'b0;  // unknown funct is a nop
                endcase
            end
            mips_lite_pkg::OP_ADDIU: begin
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            mips_lite_pkg::OP_ORI: begin
                dec.alu_op     = mips_lite_pkg::ALU_OR;
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            mips_lite_pkg::OP_LUI: begin
                dec.alu_op     = mips_lite_pkg::ALU_LUI;
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            mips_lite_pkg::OP_LW: begin
                dec.use_imm    = 1'b1;   // address = rs + imm
                dec.writes_reg = 1'b1;
                dec.is_load    = 1'b1;
            end
            mips_lite_pkg::OP_SW: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            mips_lite_pkg::OP_BEQ: dec.is_beq = 1'b1;
            mips_lite_pkg::OP_BNE: dec.is_bne = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/core_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_sequencer #(
    parameter mips_lite_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                 aclk,
    input  logic                 arst_n,
    core_bus_if.requester        bus,
    decode_if.sink               dec,
    input  mips_lite_pkg::word_t mem_addr,
    input  mips_lite_pkg::word_t store_data,
    input  logic                 take_branch,
    input  mips_lite_pkg::word_t branch_target,
    output mips_lite_pkg::word_t pc,
    output logic                 load_ir,
    output logic                 retire,
    output mips_lite_pkg::word_t load_data
);

    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, RESULT} phase_t;

    phase_t phase;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= FETCH;
            pc    <= reset_pc;
        end else begin
            case (phase)
                FETCH:  if (bus.done) phase <= DECODE;
                DECODE: phase <= EXEC;
                EXEC:   phase <= (dec.is_load || dec.is_store) ? MEM : RESULT;
                MEM:    if (bus.done) phase <= RESULT;
                RESULT: begin
                    pc    <= take_branch ? branch_target : pc + 32'd4;  // no delay slot
                    phase <= FETCH;
                end
                default: phase <= FETCH;
            endcase
        end
    end

    // lw data, held into RESULT
    always_ff @(posedge aclk) begin
        if (phase == MEM && bus.done && dec.is_load) load_data <= bus.rdata;
    end

    // fetch uses pc, data access uses the execute address
    assign bus.req   = (phase == FETCH) || (phase == MEM);
    assign bus.we    = (phase == MEM) && dec.is_store;
    assign bus.addr  = (phase == MEM) ? mem_addr : pc;
    assign bus.wdata = store_data;

    assign load_ir = (phase == FETCH) && bus.done;
    assign retire  = (phase == RESULT);

endmodule

`default_nettype wire

// ==== source/axi_lite_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_lite_bus (
    input  logic                 aclk,
    input  logic                 arst_n,
    core_bus_if.responder        bus,
    output mips_lite_pkg::word_t awaddr,
    output logic [2:0]           awprot,
    output logic                 awvalid,
    input  logic                 awready,
    output mips_lite_pkg::word_t wdata,
    output logic [3:0]           wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    input  logic [1:0]           bresp,     // not checked
    input  logic                 bvalid,
    output logic                 bready,
    output mips_lite_pkg::word_t araddr,
    output logic [2:0]           arprot,
    output logic                 arvalid,
    input  logic                 arready,
    input  mips_lite_pkg::word_t rdata,
    input  logic [1:0]           rresp,     // not checked
    input  logic                 rvalid,
    output logic                 rready
);

    typedef enum logic [2:0] {IDLE, READ_ADDR, READ_DATA, WRITE, WRITE_RESP, DONE} state_t;

    state_t               state;
    logic                 aw_done;    // aw accepted, w still pending
    logic                 w_done;
    logic                 aw_hs;
    logic                 w_hs;
    mips_lite_pkg::word_t addr_q;
    mips_lite_pkg::word_t wdata_q;
    mips_lite_pkg::word_t rdata_q;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE:      if (bus.req) state <= bus.we ? WRITE : READ_ADDR;
                READ_ADDR: if (arready) state <= READ_DATA;
                READ_DATA: if (rvalid) state <= DONE;
                WRITE: begin
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state   <= WRITE_RESP;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else begin
                        if (aw_hs) aw_done <= 1'b1;
                        if (w_hs) w_done <= 1'b1;
                    end
                end
                WRITE_RESP: if (bvalid) state <= DONE;
                default:    state <= IDLE;  // DONE
            endcase
        end
    end

    // request payload and read word
    always_ff @(posedge aclk) begin
        if (state == IDLE && bus.req) begin
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
        if (rvalid && rready) rdata_q <= rdata;
    end

    assign arvalid = (state == READ_ADDR);
    assign rready  = (state == READ_DATA);
    assign awvalid = (state == WRITE) && !aw_done;
    assign wvalid  = (state == WRITE) && !w_done;
    assign bready  = (state == WRITE_RESP);

    assign araddr = addr_q;
    assign awaddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = 4'hf;      // full words only
    assign awprot = 3'b000;
    assign arprot = 3'b000;

    assign bus.done  = (state == DONE);
    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/decode_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decode_if;

    mips_lite_pkg::reg_idx_t rs;
    mips_lite_pkg::reg_idx_t rt;
    mips_lite_pkg::reg_idx_t dest;      // rd or rt
    mips_lite_pkg::word_t    imm;       // already extended
    mips_lite_pkg::alu_op_t  alu_op;
    logic                    use_imm;
    logic                    writes_reg;
    logic                    is_load;
    logic                    is_store;
    logic                    is_beq;
    logic                    is_bne;

    modport source (output rs, rt, dest, imm, alu_op, use_imm, writes_reg,
                    is_load, is_store, is_beq, is_bne);
    modport sink   (input rs, rt, dest, imm, alu_op, use_imm, writes_reg,
                    is_load, is_store, is_beq, is_bne);

endinterface

`default_nettype wire

// ==== source/core_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one memory request from the sequencer, completed by the bus unit
interface core_bus_if;

    logic                req;    // held until done
    logic                we;
    mips_lite_pkg::word_t addr;
    mips_lite_pkg::word_t wdata;
    logic                done;   // single cycle
    mips_lite_pkg::word_t rdata;

    modport requester (output req, we, addr, wdata, input done, rdata);
    modport responder (input req, we, addr, wdata, output done, rdata);

endinterface

`default_nettype wire

// ==== source/mips_lite_pkg.sv ====
`default_nettype none

package mips_lite_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;  // signed compare
    localparam alu_op_t ALU_LUI = 3'd6;

    // primary opcode, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field for OP_SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire
